// ==== pad_input.txt ====
# columns (hex): player 1 buttons, player 2 buttons, expected player 1 NES byte,
# expected player 2 NES byte, expected reset request
000 000 00 00 0
001 002 01 02 0
0a5 05a a5 5a 0
0ff 000 ff 00 1
014 0c3 14 c3 1
c68 480 68 80 0
004 010 04 10 0
100 200 00 00 0
301 003 01 03 0
4f0 8f0 f0 f0 0

// ==== sim.f ====
gamepad_pkg.sv
snes_pad_reader.sv
autofire.sv
nes_joypad_port.sv
gamepad_top.sv
tb_gamepad.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the gamepad testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_gamepad -f sim.f -o tb_gamepad
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_gamepad > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== tb_gamepad.sv ====
/*
 * testbench for the game controller front end
 * two SNES controller models, console-side reads, checks against pad_input.txt
 */

module tb_gamepad import gamepad_pkg::*; ();

    localparam int CLK_PERIOD  = 20;
    localparam int DRIVE_DLY   = 2;     // inputs move this long after the edge
    localparam int RESET_CYC   = 3;
    localparam int POLL_CYC    = 161;   // gap + latch + 15 clocks + done
    localparam int SWEEP_READS = 24;
    localparam int SWEEP_GAP   = 16;    // 24 x 21 cycles spans > 2 turbo half-phases

    logic        clk;
    logic        sys_resetn;
    logic        joy1_strb;
    logic        joy1_clk;
    logic        joy1_data;
    logic        joy2_strb;
    logic        joy2_clk;
    logic        joy2_data;
    logic        nes_strobe;
    logic [1:0]  nes_clk;
    logic [1:0]  nes_data;
    logic        reset_req;
    logic [15:0] pad_word1;   // serial order with 1 meaning pressed
    logic [15:0] pad_word2;
    logic [3:0]  pad_idx1 = '0;
    logic [3:0]  pad_idx2 = '0;
    logic [11:0] q_btn1 [$];
    logic [11:0] q_btn2 [$];
    logic [7:0]  q_exp1 [$];
    logic [7:0]  q_exp2 [$];
    logic        q_rst [$];
    btns_t       cur_btn [2];
    logic [7:0]  exp_byte [2];
    logic [10:0] rd_bits [2];   // A first, then 3 fill bits
    logic [1:0]  seen_a [2];    // bit v set once value v was read
    logic [1:0]  seen_b [2];
    int          num_tests = 0;
    int          seed = 76391;

    gamepad_top #(
        .HALF_PERIOD     (4),
        .POLL_GAP        (32),
        .AUTOFIRE_PERIOD (200)
    ) u_dut (
        .clk          (clk),
        .sys_resetn   (sys_resetn),
        .o_joy1_strb  (joy1_strb),
        .o_joy1_clk   (joy1_clk),
        .i_joy1_data  (joy1_data),
        .o_joy2_strb  (joy2_strb),
        .o_joy2_clk   (joy2_clk),
        .i_joy2_data  (joy2_data),
        .i_nes_strobe (nes_strobe),
        .i_nes_clk    (nes_clk),
        .o_nes_data   (nes_data),
        .o_reset_req  (reset_req)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    ////////////////////
    // controller models
    ////////////////////

    always @(posedge joy1_clk or posedge joy1_strb) begin
        if (joy1_strb)
            pad_idx1 <= '0;   // bit 0 while latched
        else
            pad_idx1 <= pad_idx1 + 4'd1;
    end

    always @(posedge joy2_clk or posedge joy2_strb) begin
        if (joy2_strb)
            pad_idx2 <= '0;
        else
            pad_idx2 <= pad_idx2 + 4'd1;
    end

    assign joy1_data = ~pad_word1[pad_idx1];   // pressed reads low
    assign joy2_data = ~pad_word2[pad_idx2];

    // B Y Sel Start U D L R A X L R on the wire
    function automatic logic [15:0] to_serial(input btns_t b);
        logic [15:0] s;
        s         = '0;
        s[0]      = b[BTN_B];
        s[1]      = b[BTN_Y];
        s[7:2]    = b[7:2];
        s[8]      = b[BTN_A];
        s[9]      = b[BTN_X];
        s[11:10]  = b[11:10];
        return s;
    endfunction

    task automatic report_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic tick();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    ////////////////////
    // console side
    ////////////////////

    task automatic strobe_pulse();
        nes_strobe = 1'b1;
        tick();
        nes_strobe = 1'b0;
    endtask

    task automatic nes_pulse(input logic p);
        nes_clk[p] = 1'b0;
        tick();
        nes_clk[p] = 1'b1;
        tick();   // port must see the high level again
    endtask

    // 11 reads per player with clock pulses interleaved at random
    task automatic read_both();
        logic [3:0] cnt [2];
        logic       p;
        int         rnd;
        cnt[0] = '0;
        cnt[1] = '0;
        strobe_pulse();
        while (cnt[0] < 4'd11 || cnt[1] < 4'd11) begin
            rnd = $random(seed);
            p   = rnd[0];
            if (cnt[p] == 4'd11)
                p = ~p;
            rd_bits[p][cnt[p]] = nes_data[p];
            cnt[p] = cnt[p] + 4'd1;
            nes_pulse(p);
            repeat (rnd[3:2]) tick();
        end
    endtask

    task automatic check_bytes(input logic p);
        assert (rd_bits[p][7:0] == exp_byte[p])
        else report_error($sformatf("player %0d byte expected %h seen %h",
                                    int'(p) + 1, exp_byte[p], rd_bits[p][7:0]));
        assert (rd_bits[p][10:8] == 3'b111)
        else report_error($sformatf("player %0d fill expected 111 seen %b",
                                    int'(p) + 1, rd_bits[p][10:8]));
    endtask

    task automatic turbo_sweep();
        seen_a[0] = '0;
        seen_a[1] = '0;
        seen_b[0] = '0;
        seen_b[1] = '0;
        repeat (SWEEP_READS) begin
            strobe_pulse();
            seen_a[0][nes_data[0]] = 1'b1;
            seen_a[1][nes_data[1]] = 1'b1;
            nes_pulse(1'b0);
            nes_pulse(1'b1);
            seen_b[0][nes_data[0]] = 1'b1;
            seen_b[1][nes_data[1]] = 1'b1;
            repeat (SWEEP_GAP) tick();
        end
    endtask

    // held turbo on a released button toggles, otherwise the level is steady
    task automatic check_turbo(input logic held, input logic steady,
                               input logic [1:0] seen, input string name);
        if (held && !steady)
            assert (seen == 2'b11)
            else report_error($sformatf("%s expected 0 and 1 seen set %b", name, seen));
        else
            assert (seen == (steady ? 2'b10 : 2'b01))
            else report_error($sformatf("%s expected steady %b seen set %b",
                                        name, steady, seen));
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [11:0] b1;
        logic [11:0] b2;
        logic [7:0]  e1;
        logic [7:0]  e2;
        logic        f;
        fd = $fopen("pad_input.txt", "r");
        if (fd == 0) begin
            $display("could not open pad_input.txt");
            $display("SIMULATION FAILED");
            $fatal(1, "missing stimulus file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line[0] != "#") begin   // header lines start with #
                    n = $sscanf(line, "%h %h %h %h %h", b1, b2, e1, e2, f);
                    if (n == 5) begin
                        q_btn1.push_back(b1);
                        q_btn2.push_back(b2);
                        q_exp1.push_back(e1);
                        q_exp2.push_back(e2);
                        q_rst.push_back(f);
                    end
                end
            end
            $fclose(fd);
            num_tests = q_btn1.size();
            if (num_tests == 0) begin
                $display("pad_input.txt holds no test lines");
                $display("SIMULATION FAILED");
                $fatal(1, "empty stimulus file");
            end
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        int t;
        sys_resetn = 1'b0;
        nes_strobe = 1'b0;
        nes_clk    = 2'b11;   // console clock idles high
        pad_word1  = '0;
        pad_word2  = '0;
        load_vectors();
        repeat (RESET_CYC) tick();
        sys_resetn = 1'b1;
        tick();
        assert (nes_data == 2'b00 && reset_req == 1'b0)
        else report_error($sformatf("after reset expected data 00 req 0 seen %b %b",
                                    nes_data, reset_req));
        for (t = 0; t < num_tests; t++) begin
            cur_btn[0]  = q_btn1[t];
            cur_btn[1]  = q_btn2[t];
            exp_byte[0] = q_exp1[t];
            exp_byte[1] = q_exp2[t];
            pad_word1   = to_serial(cur_btn[0]);
            pad_word2   = to_serial(cur_btn[1]);
            repeat (2) @(negedge joy1_strb);   // second poll fully after the load
            tick();
            assert (reset_req == q_rst[t])
            else report_error($sformatf("line %0d reset request expected %b seen %b",
                                        t + 1, q_rst[t], reset_req));
            if (cur_btn[0][BTN_X] | cur_btn[0][BTN_Y] |
                cur_btn[1][BTN_X] | cur_btn[1][BTN_Y]) begin
                turbo_sweep();
                check_turbo(cur_btn[0][BTN_X], exp_byte[0][BTN_A], seen_a[0], "player 1 A");
                check_turbo(cur_btn[0][BTN_Y], exp_byte[0][BTN_B], seen_b[0], "player 1 B");
                check_turbo(cur_btn[1][BTN_X], exp_byte[1][BTN_A], seen_a[1], "player 2 A");
                check_turbo(cur_btn[1][BTN_Y], exp_byte[1][BTN_B], seen_b[1], "player 2 B");
            end else begin
                read_both();
                check_bytes(1'b0);
                check_bytes(1'b1);
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    // 3 polls per line plus the turbo sweep, then a margin
    initial begin
        int limit;
        wait (num_tests > 0);
        limit = num_tests * (3 * POLL_CYC + SWEEP_READS * (5 + SWEEP_GAP)) * CLK_PERIOD
                + 100 * CLK_PERIOD;
        #(limit);
        $display("timeout: the tests did not finish in the expected time");
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== gamepad_top.sv ====
/*
 * game controller front end
 * two SNES pad readers polled side by side, merged into the NES joypad port
 */

module gamepad_top import gamepad_pkg::*; #(
    parameter int HALF_PERIOD     = 4,
    parameter int POLL_GAP        = 32,
    parameter int AUTOFIRE_PERIOD = 200
) (
    input  logic       clk,
    input  logic       sys_resetn,

    // player 1 controller
    output logic       o_joy1_strb,
    output logic       o_joy1_clk,
    input  logic       i_joy1_data,

    // player 2 controller
    output logic       o_joy2_strb,
    output logic       o_joy2_clk,
    input  logic       i_joy2_data,

    // console side
    input  logic       i_nes_strobe,
    input  logic [1:0] i_nes_clk,
    output logic [1:0] o_nes_data,
    output logic       o_reset_req
);

    btns_t buttons1;
    btns_t buttons2;
    logic  poll_done1;

    ////////////////////
    // pad readers
    ////////////////////

    snes_pad_reader #(
        .HALF_PERIOD (HALF_PERIOD),
        .POLL_GAP    (POLL_GAP)
    ) u_reader1 (
        .clk         (clk),
        .sys_resetn  (sys_resetn),
        .o_joy_strb  (o_joy1_strb),
        .o_joy_clk   (o_joy1_clk),
        .i_joy_data  (i_joy1_data),
        .o_buttons   (buttons1),
        .o_poll_done (poll_done1)
    );

    snes_pad_reader #(
        .HALF_PERIOD (HALF_PERIOD),
        .POLL_GAP    (POLL_GAP)
    ) u_reader2 (
        .clk         (clk),
        .sys_resetn  (sys_resetn),
        .o_joy_strb  (o_joy2_strb),
        .o_joy_clk   (o_joy2_clk),
        .i_joy_data  (i_joy2_data),
        .o_buttons   (buttons2),
        .o_poll_done ()              // reset combo only watches player 1
    );

    nes_joypad_port #(
        .AUTOFIRE_PERIOD (AUTOFIRE_PERIOD)
    ) u_port (
        .clk          (clk),
        .sys_resetn   (sys_resetn),
        .i_buttons1   (buttons1),
        .i_buttons2   (buttons2),
        .i_poll_done1 (poll_done1),
        .i_nes_strobe (i_nes_strobe),
        .i_nes_clk    (i_nes_clk),
        .o_nes_data   (o_nes_data),
        .o_reset_req  (o_reset_req)
    );

endmodule

// ==== nes_joypad_port.sv ====
/*
 * NES joypad port
 * per-player shift registers answering the console strobe and clock,
 * turbo merge onto A and B, and the Select+Up reset combo from player 1
 */

module nes_joypad_port import gamepad_pkg::*; #(
    parameter int AUTOFIRE_PERIOD = 200
) (
    input  logic       clk,
    input  logic       sys_resetn,
    input  btns_t      i_buttons1,
    input  btns_t      i_buttons2,
    input  logic       i_poll_done1,
    input  logic       i_nes_strobe,
    input  logic [1:0] i_nes_clk,     // one per player
    output logic [1:0] o_nes_data,
    output logic       o_reset_req
);

    logic       phase;
    logic [1:0] nes_clk_q;   // last console clock levels
    logic [1:0] clk_fall;
    btns_t      btns [2];
    logic [7:0] nes_byte [2];
    logic [7:0] shreg [2];

    autofire #(
        .AUTOFIRE_PERIOD (AUTOFIRE_PERIOD)
    ) u_autofire (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .o_phase    (phase)
    );

    assign btns[0]  = i_buttons1;
    assign btns[1]  = i_buttons2;
    assign clk_fall = nes_clk_q & ~i_nes_clk;

    always_ff @(posedge clk) begin
        if (!sys_resetn)
            nes_clk_q <= '0;
        else
            nes_clk_q <= i_nes_clk;
    end

    ////////////////////
    // per player
    ////////////////////

    for (genvar p = 0; p < 2; p++) begin : g_player
        // X fires A, Y fires B while held
        always_comb begin
            nes_byte[p]        = btns[p][7:0];
            nes_byte[p][BTN_A] = btns[p][BTN_A] | (btns[p][BTN_X] & phase);
            nes_byte[p][BTN_B] = btns[p][BTN_B] | (btns[p][BTN_Y] & phase);
        end

        always_ff @(posedge clk) begin
            if (!sys_resetn)
                shreg[p] <= '0;
            else if (i_nes_strobe)
                shreg[p] <= nes_byte[p];             // reload every cycle
            else if (clk_fall[p])
                shreg[p] <= {1'b1, shreg[p][7:1]};   // ones after the 8th read
        end

        assign o_nes_data[p] = shreg[p][0];
    end

    // console reset request, sampled once per player 1 poll
    always_ff @(posedge clk) begin
        if (!sys_resetn)
            o_reset_req <= 1'b0;
        else if (i_poll_done1)
            o_reset_req <= i_buttons1[BTN_SELECT] & i_buttons1[BTN_UP];
    end

endmodule

// ==== autofire.sv ====
/*
 * turbo phase generator
 * square wave shared by all turbo buttons of both players
 */

module autofire #(
    parameter int AUTOFIRE_PERIOD = 200   // cycles per half-phase
) (
    input  logic clk,
    input  logic sys_resetn,
    output logic o_phase
);

    localparam int CNT_W = $clog2(AUTOFIRE_PERIOD + 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            cnt     <= CNT_W'(AUTOFIRE_PERIOD - 1);
            o_phase <= 1'b0;
        end else if (cnt == '0) begin
            cnt     <= CNT_W'(AUTOFIRE_PERIOD - 1);   // reload
            o_phase <= ~o_phase;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

// ==== snes_pad_reader.sv ====
/*
 * SNES serial pad reader
 * polls one controller with latch and clock, collects the 16 serial
 * bits and publishes the 12 button bits as one word per poll
 */

module snes_pad_reader import gamepad_pkg::*; #(
    parameter int HALF_PERIOD = 4,   // cycles per half serial clock
    parameter int POLL_GAP    = 32   // idle cycles between polls
) (
    input  logic  clk,
    input  logic  sys_resetn,
    output logic  o_joy_strb,
    output logic  o_joy_clk,
    input  logic  i_joy_data,    // active low
    output btns_t o_buttons,
    output logic  o_poll_done
);

    localparam int CNT_MAX = (POLL_GAP > 2*HALF_PERIOD) ? POLL_GAP : 2*HALF_PERIOD;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);
    localparam int IDX_W   = $clog2(SNES_BITS);

    reader_state_e    state;
    logic [CNT_W-1:0] cnt;       // cycles left in the current phase
    logic [IDX_W-1:0] bit_idx;   // serial bit on the wire
    btns_t            shadow;    // word under assembly
    logic             sample;

    // wire levels come straight from the state
    assign o_joy_strb  = (state == RD_LATCH);
    assign o_joy_clk   = (state != RD_CLK_LOW);
    assign o_poll_done = (state == RD_DONE);

    // bit 0 at the end of the latch, the rest one cycle after each rising clock
    assign sample = ((state == RD_LATCH) && (cnt == '0)) ||
                    ((state == RD_CLK_HIGH) && (cnt == CNT_W'(HALF_PERIOD - 1)));

    ////////////////////
    // sequencing
    ////////////////////

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            state     <= RD_GAP;
            cnt       <= CNT_W'(POLL_GAP - 1);
            bit_idx   <= '0;
            o_buttons <= '0;
        end else begin
            cnt <= cnt - 1'b1;
            case (state)
                RD_GAP: if (cnt == '0) begin
                    state <= RD_LATCH;
                    cnt   <= CNT_W'(2*HALF_PERIOD - 1);
                end
                RD_LATCH: if (cnt == '0) begin
                    state   <= RD_CLK_LOW;
                    cnt     <= CNT_W'(HALF_PERIOD - 1);
                    bit_idx <= IDX_W'(1);
                end
                RD_CLK_LOW: if (cnt == '0) begin
                    state <= RD_CLK_HIGH;
                    cnt   <= CNT_W'(HALF_PERIOD - 1);
                end
                RD_CLK_HIGH: if (cnt == '0) begin
                    if (bit_idx == IDX_W'(SNES_BITS - 1)) begin
                        state     <= RD_DONE;
                        o_buttons <= shadow;   // whole word at once
                    end else begin
                        state   <= RD_CLK_LOW;
                        cnt     <= CNT_W'(HALF_PERIOD - 1);
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
                RD_DONE: begin
                    state   <= RD_GAP;
                    cnt     <= CNT_W'(POLL_GAP - 1);
                    bit_idx <= '0;
                end
                default: state <= RD_GAP;
            endcase
        end
    end

    ////////////////////
    // serial to btns_t
    ////////////////////

    // SNES order is B Y Sel Start U D L R A X L R, only four bits move
    always_ff @(posedge clk) begin
        if (sample) begin
            case (bit_idx)
                IDX_W'(0): shadow[BTN_B] <= ~i_joy_data;
                IDX_W'(1): shadow[BTN_Y] <= ~i_joy_data;
                IDX_W'(8): shadow[BTN_A] <= ~i_joy_data;
                IDX_W'(9): shadow[BTN_X] <= ~i_joy_data;
                default: begin
                    if (bit_idx < IDX_W'(NUM_BTNS))   // 12..15 carry nothing
                        shadow[bit_idx] <= ~i_joy_data;
                end
            endcase
        end
    end

endmodule

// ==== gamepad_pkg.sv ====
/*
 * gamepad shared definitions
 * button word layout, button bit positions, serial frame length
 * and the SNES reader state encoding
 */

package gamepad_pkg;

    ////////////////////
    // button word
    ////////////////////

    localparam int NUM_BTNS  = 12;   // width of one player's button word
    localparam int SNES_BITS = 16;   // serial bits clocked out per poll

    // 1 = pressed
    // [7:0]  A B Select Start Up Down Left Right (NES serial order)
    // [11:8] X Y L R
    typedef logic [NUM_BTNS-1:0] btns_t;

    localparam int BTN_A      = 0;
    localparam int BTN_B      = 1;
    localparam int BTN_SELECT = 2;
    localparam int BTN_UP     = 4;
    localparam int BTN_X      = 8;
    localparam int BTN_Y      = 9;

    ////////////////////
    // reader FSM
    ////////////////////

    typedef enum logic [2:0] {
        RD_GAP,        // idle between polls, latch low, clock high
        RD_LATCH,      // latch pulse, bit 0 on the wire
        RD_CLK_LOW,    // first half of a serial clock
        RD_CLK_HIGH,   // second half, bit sampled right after the edge
        RD_DONE        // publish word, one cycle
    } reader_state_e;

endpackage
